//--- mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Boot ROM base, where fetch starts out of reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// Fetching this address stops the core
`define MIPS_HALT_ADDR 32'h0000_0000

// Link target of JAL ($ra)
`define MIPS_REG_RA 5'd31

// Result register exported on register_v0
`define MIPS_REG_V0 5'd2

`endif

//--- mips_pkg.sv
package mips_pkg;

	typedef struct packed {
		logic [5:0] op;	// Primary opcode
		logic [4:0] rs;	// Source A
		logic [4:0] rt;	// Source B
		logic [4:0] rd;	// Destination
		logic [4:0] shamt;	// Shift amount
		logic [5:0] funct;	// R-type sub-opcode
	} r_format_t;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;	// Base or source
		logic [4:0] rt;	// Destination or store data
		logic [15:0] imm;	// Offset or literal
	} i_format_t;

	// One fetched word, two views of the same bits
	typedef union packed {
		r_format_t r;
		i_format_t i;
	} instr_t;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'b000000,
		OP_J = 6'b000010,
		OP_JAL = 6'b000011,
		OP_BEQ = 6'b000100,
		OP_BNE = 6'b000101,
		OP_ADDIU = 6'b001001,
		OP_SLTI = 6'b001010,
		OP_SLTIU = 6'b001011,
		OP_ANDI = 6'b001100,
		OP_ORI = 6'b001101,
		OP_XORI = 6'b001110,
		OP_LUI = 6'b001111,
		OP_LW = 6'b100011,
		OP_SW = 6'b101011
	} opcode_e;

	typedef enum logic [5:0] {
		F_SLL = 6'b000000,
		F_SRL = 6'b000010,
		F_SRA = 6'b000011,
		F_SLLV = 6'b000100,
		F_SRLV = 6'b000110,
		F_SRAV = 6'b000111,
		F_JR = 6'b001000,
		F_JALR = 6'b001001,
		F_ADDU = 6'b100001,
		F_SUBU = 6'b100011,
		F_AND = 6'b100100,
		F_OR = 6'b100101,
		F_XOR = 6'b100110,
		F_SLT = 6'b101010,
		F_SLTU = 6'b101011
	} funct_e;

	// Coarse ALU request from the main decoder
	typedef enum logic [1:0] {ADD, SUB, FUNCT, IMM_OP} alu_class_e;

	typedef enum logic [3:0] {
		ADDU, SUBU, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA, LUI
	} alu_op_e;

endpackage

//--- mips_main_decoder.sv
`timescale 1ns/1ps

module mips_main_decoder (
	input mips_pkg::instr_t instr,
	output logic reg_write,	// Write back to register file
	output logic reg_dst_rd,	// Destination is rd, not rt
	output logic link,	// Write back PC+4
	output logic alu_src_imm,	// ALU b from immediate
	output logic shift_imm,	// Shift amount from shamt field
	output logic mem_to_reg,	// Write back load data
	output logic mem_read,
	output logic mem_write,
	output logic branch,
	output logic branch_ne,	// Branch on not equal
	output logic jump,
	output logic jump_reg,	// Target from rs
	output logic zero_ext,	// Logical immediates
	output mips_pkg::alu_class_e alu_class
);

	always_comb begin
		reg_write = 1'b0;	// Illegal words just advance the PC
		reg_dst_rd = 1'b0;
		link = 1'b0;
		alu_src_imm = 1'b0;
		shift_imm = 1'b0;
		mem_to_reg = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		branch = 1'b0;
		branch_ne = 1'b0;
		jump = 1'b0;
		jump_reg = 1'b0;
		zero_ext = 1'b0;
		alu_class = mips_pkg::ADD;
		case (instr.r.op)
			mips_pkg::OP_RTYPE: begin
				case (instr.r.funct)
					mips_pkg::F_JR: jump_reg = 1'b1;
					mips_pkg::F_JALR: begin
						jump_reg = 1'b1;
						reg_write = 1'b1;	// Link goes to rd
						reg_dst_rd = 1'b1;
						link = 1'b1;
					end
					mips_pkg::F_SLL, mips_pkg::F_SRL, mips_pkg::F_SRA: begin
						reg_write = 1'b1;
						reg_dst_rd = 1'b1;
						shift_imm = 1'b1;	// Constant shift
						alu_class = mips_pkg::FUNCT;
					end
					mips_pkg::F_SLLV, mips_pkg::F_SRLV, mips_pkg::F_SRAV,
					mips_pkg::F_ADDU, mips_pkg::F_SUBU, mips_pkg::F_AND,
					mips_pkg::F_OR, mips_pkg::F_XOR, mips_pkg::F_SLT,
					mips_pkg::F_SLTU: begin
						reg_write = 1'b1;
						reg_dst_rd = 1'b1;
						alu_class = mips_pkg::FUNCT;
					end
					default: ;	// Unsupported funct, treated as NOP
				endcase
			end
			mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU: begin
				reg_write = 1'b1;
				alu_src_imm = 1'b1;	// Sign-extended literal
				alu_class = mips_pkg::IMM_OP;
			end
			mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
				reg_write = 1'b1;
				alu_src_imm = 1'b1;
				zero_ext = 1'b1;	// Upper half cleared
				alu_class = mips_pkg::IMM_OP;
			end
			mips_pkg::OP_LW: begin
				reg_write = 1'b1;
				alu_src_imm = 1'b1;	// Base plus offset
				mem_to_reg = 1'b1;
				mem_read = 1'b1;
			end
			mips_pkg::OP_SW: begin
				alu_src_imm = 1'b1;
				mem_write = 1'b1;
			end
			mips_pkg::OP_BEQ: begin
				branch = 1'b1;
				alu_class = mips_pkg::SUB;	// Compare through zero flag
			end
			mips_pkg::OP_BNE: begin
				branch = 1'b1;
				branch_ne = 1'b1;
				alu_class = mips_pkg::SUB;
			end
			mips_pkg::OP_J: jump = 1'b1;
			mips_pkg::OP_JAL: begin
				jump = 1'b1;
				reg_write = 1'b1;	// $ra gets PC+4
				link = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

//--- mips_alu_decoder.sv
`timescale 1ns/1ps

module mips_alu_decoder (
	input mips_pkg::alu_class_e alu_class,
	input mips_pkg::instr_t instr,
	output mips_pkg::alu_op_e alu_op
);

	always_comb begin
		alu_op = mips_pkg::ADDU;	// Address math by default
		case (alu_class)
			mips_pkg::ADD: alu_op = mips_pkg::ADDU;	// Loads and stores
			mips_pkg::SUB: alu_op = mips_pkg::SUBU;	// Branch compare
			mips_pkg::FUNCT: begin
				case (instr.r.funct)
					mips_pkg::F_ADDU: alu_op = mips_pkg::ADDU;
					mips_pkg::F_SUBU: alu_op = mips_pkg::SUBU;
					mips_pkg::F_AND: alu_op = mips_pkg::AND;
					mips_pkg::F_OR: alu_op = mips_pkg::OR;
					mips_pkg::F_XOR: alu_op = mips_pkg::XOR;
					mips_pkg::F_SLT: alu_op = mips_pkg::SLT;
					mips_pkg::F_SLTU: alu_op = mips_pkg::SLTU;
					// Variable forms differ only in shamt source
					mips_pkg::F_SLL, mips_pkg::F_SLLV: alu_op = mips_pkg::SLL;
					mips_pkg::F_SRL, mips_pkg::F_SRLV: alu_op = mips_pkg::SRL;
					mips_pkg::F_SRA, mips_pkg::F_SRAV: alu_op = mips_pkg::SRA;
					default: alu_op = mips_pkg::ADDU;	// JR, JALR ignore the ALU
				endcase
			end
			mips_pkg::IMM_OP: begin
				case (instr.i.op)
					mips_pkg::OP_ANDI: alu_op = mips_pkg::AND;
					mips_pkg::OP_ORI: alu_op = mips_pkg::OR;
					mips_pkg::OP_XORI: alu_op = mips_pkg::XOR;
					mips_pkg::OP_SLTI: alu_op = mips_pkg::SLT;
					mips_pkg::OP_SLTIU: alu_op = mips_pkg::SLTU;	// Literal still sign-extended
					mips_pkg::OP_LUI: alu_op = mips_pkg::LUI;
					default: alu_op = mips_pkg::ADDU;	// ADDIU
				endcase
			end
			default: alu_op = mips_pkg::ADDU;
		endcase
	end

endmodule

//--- mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
	input mips_pkg::alu_op_e alu_op,
	input logic [31:0] a,
	input logic [31:0] b,
	input logic [4:0] shamt,	// Already muxed between field and rs
	output logic [31:0] result,
	output logic zero
);

	logic [31:0] sum;
	logic [31:0] diff;
	logic lt_signed;
	logic lt_unsigned;

	assign sum = a + b;	// No overflow trap
	assign diff = a - b;
	assign lt_signed = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (alu_op)
			mips_pkg::ADDU: result = sum;
			mips_pkg::SUBU: result = diff;
			mips_pkg::AND: result = a & b;
			mips_pkg::OR: result = a | b;
			mips_pkg::XOR: result = a ^ b;
			mips_pkg::SLT: result = {31'b0, lt_signed};	// 1 or 0
			mips_pkg::SLTU: result = {31'b0, lt_unsigned};
			mips_pkg::SLL: result = b << shamt;	// Shifts act on rt
			mips_pkg::SRL: result = b >> shamt;
			mips_pkg::SRA: result = $signed(b) >>> shamt;	// Sign fill
			mips_pkg::LUI: result = {b[15:0], 16'b0};
			default: result = sum;
		endcase
	end

	// Drives BEQ and BNE resolution
	assign zero = (result == 32'b0);

endmodule

//--- mips_regfile.sv
`timescale 1ns/1ps

`include "mips_params.svh"

module mips_regfile (
	input logic clk,
	input logic write_en,	// Already qualified by the datapath
	input logic [4:0] read_addr_a,
	input logic [4:0] read_addr_b,
	input logic [4:0] write_addr,
	input logic [31:0] write_data,
	output logic [31:0] read_data_a,
	output logic [31:0] read_data_b,
	output logic [31:0] v0
);

	logic [31:0] regs [32];	// Contents undefined after power-up

	always_ff @(posedge clk) begin
		if (write_en) begin
			regs[write_addr] <= write_data;	// Writes to $zero land but never read back
		end
	end

	// $zero forced on both read ports
	assign read_data_a = (read_addr_a == 5'd0) ? 32'b0 : regs[read_addr_a];
	assign read_data_b = (read_addr_b == 5'd0) ? 32'b0 : regs[read_addr_b];

	assign v0 = regs[`MIPS_REG_V0];	// Debug tap for register_v0

endmodule

//--- mips_datapath.sv
`timescale 1ns/1ps

`include "mips_params.svh"

module mips_datapath (
	input logic clk,
	input logic reset,
	input logic clk_enable,	// Global stall
	input mips_pkg::instr_t instr,
	input mips_pkg::alu_op_e alu_op,
	input logic reg_write,
	input logic reg_dst_rd,
	input logic link,
	input logic alu_src_imm,
	input logic shift_imm,
	input logic mem_to_reg,
	input logic mem_read,
	input logic mem_write,
	input logic branch,
	input logic branch_ne,
	input logic jump,
	input logic jump_reg,
	input logic zero_ext,
	input logic [31:0] data_readdata,	// Same-cycle load data
	output logic [31:0] instr_address,
	output logic [31:0] data_address,
	output logic [31:0] data_writedata,
	output logic [31:0] register_v0,
	output logic data_read,
	output logic data_write,
	output logic active
);

	logic [31:0] pc;
	logic [31:0] pc_plus4;
	logic [31:0] pc_next;
	logic [31:0] imm_ext;
	logic [31:0] branch_target;
	logic [31:0] jump_target;
	logic branch_taken;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic [31:0] alu_b;
	logic [31:0] alu_result;
	logic [4:0] shamt;
	logic alu_zero;
	logic [4:0] dest_reg;
	logic [31:0] write_back;
	logic retire;

	assign retire = clk_enable & active;	// Instruction completes on this edge

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= `MIPS_RESET_VECTOR;
			active <= 1'b1;
		end else if (retire) begin
			pc <= pc_next;
			if (pc_next == `MIPS_HALT_ADDR) begin
				active <= 1'b0;	// Halt after this instruction retires
			end
		end
	end

	assign instr_address = pc;
	assign pc_plus4 = pc + 32'd4;	// No delay slot

	// Logical immediates clear the upper half
	assign imm_ext = zero_ext ? {16'b0, instr.i.imm} : {{16{instr.i.imm[15]}}, instr.i.imm};
	assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
	// J-format target, 26 bits taken from the I view
	assign jump_target = {pc_plus4[31:28], instr.i.rs, instr.i.rt, instr.i.imm, 2'b00};
	assign branch_taken = branch & (alu_zero ^ branch_ne);

	always_comb begin
		if (jump_reg) pc_next = rs_data;	// JR, JALR
		else if (jump) pc_next = jump_target;
		else if (branch_taken) pc_next = branch_target;
		else pc_next = pc_plus4;
	end

	// rd for R-type, $ra for JAL, rt otherwise
	assign dest_reg = reg_dst_rd ? instr.r.rd : (link ? `MIPS_REG_RA : instr.r.rt);
	assign write_back = link ? pc_plus4 : (mem_to_reg ? data_readdata : alu_result);

	mips_regfile u_regfile (
		.clk(clk),
		.write_en(reg_write & retire),	// Frozen when stalled or halted
		.read_addr_a(instr.r.rs),
		.read_addr_b(instr.r.rt),
		.write_addr(dest_reg),
		.write_data(write_back),
		.read_data_a(rs_data),
		.read_data_b(rt_data),
		.v0(register_v0)
	);

	assign alu_b = alu_src_imm ? imm_ext : rt_data;
	assign shamt = shift_imm ? instr.r.shamt : rs_data[4:0];	// SLLV family uses rs

	mips_alu u_alu (
		.alu_op(alu_op),
		.a(rs_data),
		.b(alu_b),
		.shamt(shamt),
		.result(alu_result),
		.zero(alu_zero)
	);

	assign data_address = alu_result;
	assign data_writedata = rt_data;
	assign data_read = mem_read & active;	// Quiet once halted
	assign data_write = mem_write & active;

endmodule

//--- mips_cpu_harvard.sv
`timescale 1ns/1ps

module mips_cpu_harvard (
	input logic clk,
	input logic reset,
	output logic active,
	output logic [31:0] register_v0,
	input logic clk_enable,
	output logic [31:0] instr_address,	// Current PC
	input logic [31:0] instr_readdata,
	output logic [31:0] data_address,	// ALU result
	output logic data_write,
	output logic data_read,
	output logic [31:0] data_writedata,
	input logic [31:0] data_readdata
);

	mips_pkg::instr_t instr;
	mips_pkg::alu_class_e alu_class;
	mips_pkg::alu_op_e alu_op;
	logic reg_write;
	logic reg_dst_rd;
	logic link;
	logic alu_src_imm;
	logic shift_imm;
	logic mem_to_reg;
	logic mem_read;
	logic mem_write;
	logic branch;
	logic branch_ne;
	logic jump;
	logic jump_reg;
	logic zero_ext;

	assign instr = instr_readdata;	// Fetched word seen through the union

	mips_main_decoder u_main_decoder (
		.instr(instr),
		.reg_write(reg_write),
		.reg_dst_rd(reg_dst_rd),
		.link(link),
		.alu_src_imm(alu_src_imm),
		.shift_imm(shift_imm),
		.mem_to_reg(mem_to_reg),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.branch(branch),
		.branch_ne(branch_ne),
		.jump(jump),
		.jump_reg(jump_reg),
		.zero_ext(zero_ext),
		.alu_class(alu_class)
	);

	mips_alu_decoder u_alu_decoder (
		.alu_class(alu_class),
		.instr(instr),
		.alu_op(alu_op)
	);

	mips_datapath u_datapath (
		.clk(clk),
		.reset(reset),
		.clk_enable(clk_enable),
		.instr(instr),
		.alu_op(alu_op),
		.reg_write(reg_write),
		.reg_dst_rd(reg_dst_rd),
		.link(link),
		.alu_src_imm(alu_src_imm),
		.shift_imm(shift_imm),
		.mem_to_reg(mem_to_reg),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.branch(branch),
		.branch_ne(branch_ne),
		.jump(jump),
		.jump_reg(jump_reg),
		.zero_ext(zero_ext),
		.data_readdata(data_readdata),
		.instr_address(instr_address),
		.data_address(data_address),
		.data_writedata(data_writedata),
		.register_v0(register_v0),
		.data_read(data_read),
		.data_write(data_write),
		.active(active)
	);

endmodule

//--- mips_cpu_checker.sv
`timescale 1ns/1ps

module mips_cpu_checker (
	input logic clk,
	input logic reset,
	input logic active,
	input logic clk_enable,
	input logic [31:0] instr_address,
	input logic data_read,
	input logic data_write
);

	// One data access per instruction at most
	strobe_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(data_read && data_write))
		else $error("data_read and data_write high together");

	// Halted core leaves memory alone
	halted_quiet: assert property (@(posedge clk) disable iff (reset)
		!active |-> (!data_read && !data_write))
		else $error("memory strobe while halted");

	stall_holds_pc: assert property (@(posedge clk) disable iff (reset)
		!clk_enable |=> $stable(instr_address))
		else $error("instr_address moved on a stalled edge");

endmodule

bind mips_cpu_harvard mips_cpu_checker u_checker (
	.clk(clk),
	.reset(reset),
	.active(active),
	.clk_enable(clk_enable),
	.instr_address(instr_address),
	.data_read(data_read),
	.data_write(data_write)
);

//--- tb_mips_cpu_harvard.sv
`timescale 1ns/1ps

`include "mips_params.svh"

module tb_mips_cpu_harvard;

	localparam int NUM_ROWS = 7;
	localparam int ROM_WORDS = 64;
	localparam int RAM_WORDS = 256;
	localparam int POST_HALT_CYCLES = 5;	// Idle edges watched after halt

	// MIPS opcodes and funct codes, from the ISA manual
	localparam logic [5:0] OPC_J = 6'h02;
	localparam logic [5:0] OPC_JAL = 6'h03;
	localparam logic [5:0] OPC_BEQ = 6'h04;
	localparam logic [5:0] OPC_BNE = 6'h05;
	localparam logic [5:0] OPC_ADDIU = 6'h09;
	localparam logic [5:0] OPC_SLTI = 6'h0a;
	localparam logic [5:0] OPC_ANDI = 6'h0c;
	localparam logic [5:0] OPC_ORI = 6'h0d;
	localparam logic [5:0] OPC_LUI = 6'h0f;
	localparam logic [5:0] OPC_LW = 6'h23;
	localparam logic [5:0] OPC_SW = 6'h2b;
	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_SRA = 6'h03;
	localparam logic [5:0] FN_SLLV = 6'h04;
	localparam logic [5:0] FN_SRLV = 6'h06;
	localparam logic [5:0] FN_JR = 6'h08;
	localparam logic [5:0] FN_JALR = 6'h09;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	// sw $0, 0($0), what a halted core fetches from address zero
	localparam logic [31:0] UNMAPPED_WORD = 32'hac00_0000;

	logic clk;
	logic reset;
	logic clk_enable;
	logic active;
	logic [31:0] register_v0;
	logic [31:0] instr_address;
	logic [31:0] instr_readdata;
	logic [31:0] data_address;
	logic data_write;
	logic data_read;
	logic [31:0] data_writedata;
	logic [31:0] data_readdata;

	logic [31:0] rom [ROM_WORDS];
	logic [31:0] ram [RAM_WORDS];
	logic [31:0] rom_offset;
	logic stall_mode;

	// Test table, one row per run
	int prog_id [NUM_ROWS];
	logic row_stall [NUM_ROWS];
	logic [31:0] exp_v0 [NUM_ROWS];
	int exp_count [NUM_ROWS];
	logic has_store [NUM_ROWS];	// Store rows also load the word back
	logic [31:0] st_addr [NUM_ROWS];
	logic [31:0] st_data [NUM_ROWS];

	mips_cpu_harvard DUT (
		.clk(clk),
		.reset(reset),
		.active(active),
		.register_v0(register_v0),
		.clk_enable(clk_enable),
		.instr_address(instr_address),
		.instr_readdata(instr_readdata),
		.data_address(data_address),
		.data_write(data_write),
		.data_read(data_read),
		.data_writedata(data_writedata),
		.data_readdata(data_readdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

	// ROM indexed by word offset from the boot vector
	assign rom_offset = instr_address - `MIPS_RESET_VECTOR;
	assign instr_readdata = (rom_offset[31:8] == 24'b0) ? rom[rom_offset[7:2]] : UNMAPPED_WORD;
	assign data_readdata = ram[data_address[9:2]];	// Same-cycle load data

	always @(posedge clk) begin
		if (data_write && clk_enable) begin
			ram[data_address[9:2]] <= data_writedata;
		end
	end

	// Random stalls while stall_mode is set
	initial begin
		clk_enable = 1'b0;
		void'($urandom(32'haa1d_a70c));
		forever begin
			@(posedge clk);
			clk_enable <= stall_mode ? ($urandom_range(3) != 0) : 1'b1;	// About one stall in four
		end
	end

	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [31:0] target);
		return {op, target[27:2]};	// Region bits come from PC+4
	endfunction

	function automatic logic [31:0] word_addr(input int k);
		return `MIPS_RESET_VECTOR + 32'(k * 4);
	endfunction

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic fill_table();
		prog_id = '{0, 1, 2, 3, 3, 2, 0};
		row_stall = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};	// Last three repeat with stalls
		exp_v0 = '{32'h0000_0046, 32'h091a_7800, 32'hdead_beef, 32'h7f80_0048,
			32'h7f80_0048, 32'hdead_beef, 32'h0000_0046};
		exp_count = '{9, 8, 6, 12, 12, 6, 9};
		has_store = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
		st_addr = '{32'h0, 32'h0, 32'h108, 32'h0, 32'h0, 32'h108, 32'h0};
		st_data = '{32'h0, 32'h0, 32'hdead_beef, 32'h0, 32'h0, 32'hdead_beef, 32'h0};
	endtask

	task automatic load_program(input int id);
		for (int k = 0; k < ROM_WORDS; k++) rom[k] = 32'h0;
		for (int k = 0; k < RAM_WORDS; k++) ram[k] = 32'hc0de_0000 | 32'(k);	// Address-tagged fill
		case (id)
			0: begin	// Arithmetic and shifts, v0 = 0x46
				rom[0] = enc_i(OPC_ADDIU, 5'd0, 5'd1, 16'h0005);
				rom[1] = enc_i(OPC_ADDIU, 5'd0, 5'd3, 16'hfffd);	// -3
				rom[2] = enc_r(5'd1, 5'd3, 5'd2, 5'd0, FN_ADDU);	// 2
				rom[3] = enc_r(5'd0, 5'd2, 5'd2, 5'd4, FN_SLL);	// 0x20
				rom[4] = enc_r(5'd2, 5'd3, 5'd2, 5'd0, FN_SUBU);	// 0x23
				rom[5] = enc_r(5'd0, 5'd3, 5'd4, 5'd1, FN_SRA);	// -2
				rom[6] = enc_i(OPC_SLTI, 5'd4, 5'd5, 16'hffff);	// -2 < -1
				rom[7] = enc_r(5'd5, 5'd2, 5'd2, 5'd0, FN_SLLV);
				rom[8] = enc_r(5'd0, 5'd0, 5'd0, 5'd0, FN_JR);
			end
			1: begin	// Logic, LUI, unsigned compare
				rom[0] = enc_i(OPC_LUI, 5'd0, 5'd1, 16'h1234);
				rom[1] = enc_i(OPC_ORI, 5'd1, 5'd1, 16'hff00);	// Zero-extended
				rom[2] = enc_i(OPC_ANDI, 5'd1, 5'd4, 16'h0ff0);	// 0x0f00
				rom[3] = enc_r(5'd1, 5'd4, 5'd2, 5'd0, FN_XOR);	// 0x1234f000
				rom[4] = enc_i(OPC_ADDIU, 5'd0, 5'd6, 16'hffff);
				rom[5] = enc_r(5'd4, 5'd6, 5'd7, 5'd0, FN_SLTU);	// 1
				rom[6] = enc_r(5'd7, 5'd2, 5'd2, 5'd0, FN_SRLV);
				rom[7] = enc_r(5'd0, 5'd0, 5'd0, 5'd0, FN_JR);
			end
			2: begin	// Store then load back
				rom[0] = enc_i(OPC_ADDIU, 5'd0, 5'd1, 16'h0100);
				rom[1] = enc_i(OPC_LUI, 5'd0, 5'd5, 16'hdead);
				rom[2] = enc_i(OPC_ORI, 5'd5, 5'd5, 16'hbeef);
				rom[3] = enc_i(OPC_SW, 5'd1, 5'd5, 16'h0008);	// 0x108
				rom[4] = enc_i(OPC_LW, 5'd1, 5'd2, 16'h0008);
				rom[5] = enc_r(5'd0, 5'd0, 5'd0, 5'd0, FN_JR);
			end
			3: begin	// Branches, jumps and links, 12 retire
				rom[0] = enc_i(OPC_ADDIU, 5'd0, 5'd1, 16'h0001);
				rom[1] = enc_i(OPC_BEQ, 5'd1, 5'd0, 16'h0005);	// Not taken
				rom[2] = enc_i(OPC_BNE, 5'd1, 5'd0, 16'h0001);	// To word 4
				rom[3] = enc_i(OPC_ADDIU, 5'd0, 5'd2, 16'h0055);
				rom[4] = enc_j(OPC_J, word_addr(6));
				rom[5] = enc_i(OPC_ADDIU, 5'd0, 5'd2, 16'h0066);
				rom[6] = enc_j(OPC_JAL, word_addr(8));	// ra = word 7
				rom[7] = enc_i(OPC_ADDIU, 5'd0, 5'd2, 16'h0077);
				rom[8] = enc_i(OPC_LUI, 5'd0, 5'd3, 16'hbfc0);
				rom[9] = enc_i(OPC_ORI, 5'd3, 5'd3, 16'h0030);	// Word 12
				rom[10] = enc_r(5'd3, 5'd0, 5'd2, 5'd0, FN_JALR);	// v0 = word 11
				rom[11] = enc_i(OPC_ADDIU, 5'd0, 5'd2, 16'h0088);
				rom[12] = enc_r(5'd2, 5'd31, 5'd2, 5'd0, FN_ADDU);	// Sum of both links
				rom[13] = enc_i(OPC_BEQ, 5'd0, 5'd0, 16'h0001);	// Taken, skips word 14
				rom[14] = enc_i(OPC_ADDIU, 5'd0, 5'd2, 16'h0099);
				rom[15] = enc_i(OPC_BNE, 5'd1, 5'd1, 16'h0001);	// Not taken
				rom[16] = enc_r(5'd0, 5'd0, 5'd0, 5'd0, FN_JR);
			end
			default: abort_run("unknown program number in the test table");
		endcase
	endtask

	task automatic run_row(input int row);
		int retired;
		logic store_seen;
		logic load_seen;
		logic stalled;
		logic [31:0] held_addr;
		retired = 0;
		store_seen = 1'b0;
		load_seen = 1'b0;
		stalled = 1'b0;
		held_addr = 32'h0;
		load_program(prog_id[row]);
		@(posedge clk);
		reset <= 1'b1;
		stall_mode <= row_stall[row];
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("instr_address", instr_address, `MIPS_RESET_VECTOR);
		check_value("active", {31'b0, active}, 32'h1);
		while (active) begin
			if (stalled) check_value("instr_address", instr_address, held_addr);	// No move
			stalled = !clk_enable;
			held_addr = instr_address;
			if (data_write) begin
				if (!has_store[row]) abort_run("data_write seen in a program without a store");
				check_value("data_address", data_address, st_addr[row]);
				check_value("data_writedata", data_writedata, st_data[row]);
				if (clk_enable) store_seen = 1'b1;
			end
			if (data_read) begin
				if (!has_store[row]) abort_run("data_read seen in a program without a load");
				check_value("data_address", data_address, st_addr[row]);	// Same word read back
				if (clk_enable) load_seen = 1'b1;
			end
			if (clk_enable) retired++;	// Retires on the coming edge
			@(negedge clk);
		end
		check_value("register_v0", register_v0, exp_v0[row]);
		check_value("retire_count", 32'(retired), 32'(exp_count[row]));
		if (store_seen != has_store[row]) abort_run("expected store never reached data memory");
		if (load_seen != has_store[row]) abort_run("expected load never issued to data memory");
		repeat (POST_HALT_CYCLES) begin
			check_value("instr_address", instr_address, `MIPS_HALT_ADDR);
			check_value("active", {31'b0, active}, 32'h0);
			check_value("data_write", {31'b0, data_write}, 32'h0);	// Fetched store dropped
			check_value("data_read", {31'b0, data_read}, 32'h0);
			@(negedge clk);
		end
	endtask

	initial begin
		reset = 1'b1;
		stall_mode = 1'b0;
		fill_table();
		for (int r = 0; r < NUM_ROWS; r++) run_row(r);
		$display("sim passed");
		$finish;
	end

	// Limit from the total expected retire count
	initial begin
		int total;
		total = 0;
		#1;
		for (int r = 0; r < NUM_ROWS; r++) total += exp_count[r];
		#((total * 4 + 100) * 4);
		$display("watchdog expired before all programs halted");
		$display("sim failed");
		$fatal(1);
	end

endmodule

//--- filelist.f
+incdir+.
mips_pkg.sv
mips_main_decoder.sv
mips_alu_decoder.sv
mips_alu.sv
mips_regfile.sv
mips_datapath.sv
mips_cpu_harvard.sv
mips_cpu_checker.sv
tb_mips_cpu_harvard.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_mips_cpu_harvard
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
